//--- logic/sub_bus_pkg.sv
package sub_bus_pkg;

    // word address, byte address bits 19..1
    typedef logic [19:1] addr_t;

    // bus data word
    typedef logic [15:0] data_t;

    // {uds_n, lds_n}, active low
    typedef logic [1:0] dsn_t;

    // 68000 function code
    typedef logic [2:0] fc_t;

    // who drives the sub bus
    typedef enum logic [1:0] {
        own_sub  = 2'd0,  // sub CPU runs
        own_wait = 2'd1,  // request seen, sub CPU finishing its cycle
        own_main = 2'd2   // main CPU holds the bus
    } owner_e;

    // region codes on address bits 19..17
    localparam logic [2:0] region_rom  = 3'd2;  // highest ROM code, 0..2 map to ROM
    localparam logic [2:0] region_ram  = 3'd3;
    localparam logic [2:0] region_road = 3'd4;  // bit 16 splits road RAM and sio

    // function code of an interrupt acknowledge
    localparam fc_t fc_int_ack = 3'd7;

    // read value for sio and unmapped space
    localparam data_t open_bus = 16'hffff;

endpackage

//--- logic/sub_bus_if.sv
`timescale 1ns/100ps

// internal sub bus seen by the decoder, driven by whichever master owns it
interface sub_bus_if
    import sub_bus_pkg::*;
();

    addr_t addr;    // word address of the owning master
    dsn_t  dsn;     // data strobes
    logic  rnw;     // high on reads
    data_t wdata;   // write data
    logic  active;  // cycle in progress on the bus

    modport master (
        output addr,
        output dsn,
        output rnw,
        output wdata,
        output active
    );

    modport slave (
        input addr,
        input dsn,
        input rnw,
        input wdata,
        input active
    );

endinterface

//--- logic/bus_grant_ctrl.sv
`timescale 1ns/100ps

module bus_grant_ctrl
    import sub_bus_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             sub_br,      // request from the main CPU
    input  logic             as_n,        // sub CPU address strobe
    input  logic             cpu_cen,
    input  addr_t            cpu_addr,
    input  dsn_t             cpu_dsn,
    input  logic             cpu_rnw,
    input  data_t            cpu_wdata,
    input  fc_t              fc,
    input  addr_t            main_addr,
    input  dsn_t             main_dsn,
    input  logic             main_rnw,
    input  data_t            main_wdata,
    output owner_e           owner,
    output logic             bgack_n,
    sub_bus_if.master        bus
);

    // owner FSM, br_n is only looked at on the CPU clock enable
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner   <= own_sub;
            bgack_n <= 1'b1;
        end else begin
            case (owner)
                own_sub: begin
                    if (cpu_cen && sub_br) owner <= own_wait;  // br_n sampled low
                end
                own_wait: begin
                    if (!sub_br) begin
                        owner <= own_sub;            // request withdrawn
                    end else if (cpu_cen && as_n) begin
                        owner   <= own_main;         // sub CPU between cycles
                        bgack_n <= 1'b0;
                    end
                end
                own_main: begin
                    if (!sub_br) begin
                        owner   <= own_sub;
                        bgack_n <= 1'b1;
                    end
                end
                default: begin
                    owner   <= own_sub;
                    bgack_n <= 1'b1;
                end
            endcase
        end
    end

    // bgack_n high hands the bus to the sub CPU
    assign bus.addr   = bgack_n ? cpu_addr  : main_addr;
    assign bus.dsn    = bgack_n ? cpu_dsn   : main_dsn;
    assign bus.rnw    = bgack_n ? cpu_rnw   : main_rnw;
    assign bus.wdata  = bgack_n ? cpu_wdata : main_wdata;
    assign bus.active = (~bgack_n & sub_br) | (~as_n & (fc != fc_int_ack));

    grant_off_in_sub: assert property (@(posedge clk) disable iff (rst)
        owner == own_sub |-> bgack_n);

endmodule

//--- logic/mem_map_decode.sv
`timescale 1ns/100ps

module mem_map_decode
    import sub_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    sub_bus_if.slave    bus,
    output logic        rom_cs,
    output logic        ram_cs,
    output logic        road_cs,
    output logic        sio_cs,
    output logic [18:1] sub_addr
);

    logic [2:0] region;
    logic       any_strobe;

    assign region     = bus.addr[19:17];
    assign any_strobe = ~&bus.dsn;
    assign sub_addr   = bus.addr[18:1];  // memories see the low 18 bits

    // selects follow active with one clock of delay
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs  <= 1'b0;
            ram_cs  <= 1'b0;
            road_cs <= 1'b0;
            sio_cs  <= 1'b0;
        end else begin
            rom_cs  <= 1'b0;
            ram_cs  <= 1'b0;
            road_cs <= 1'b0;
            sio_cs  <= 1'b0;
            if (bus.active) begin
                if (region <= region_rom) begin
                    rom_cs <= 1'b1;
                end else if (region == region_ram) begin
                    ram_cs <= bus.rnw | any_strobe;  // no write without a strobe
                end else if (region == region_road) begin
                    road_cs <= ~bus.addr[16];
                    sio_cs  <=  bus.addr[16];
                end
                // codes 5..7 are unmapped
            end
        end
    end

    one_select: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_cs, road_cs, sio_cs}));

endmodule

//--- logic/cycle_term.sv
`timescale 1ns/100ps

module cycle_term
    import sub_bus_pkg::*;
#(
    parameter logic [6:0] cen_num = 7'd29,   // enables per period
    parameter logic [7:0] cen_den = 8'd146   // clocks per period
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       as_n,
    input  fc_t        fc,
    input  dsn_t       cpu_dsn,
    input  logic       rom_cs,
    input  logic       rom_ok,
    input  logic       ram_cs,
    input  logic       ram_ok,
    input  logic       irq_n,
    output logic       cpu_cen,
    output logic       cpu_cenb,
    output logic       dtack_n,
    output logic       vpa_n,
    output logic [2:0] ipl_n
);

    localparam logic [8:0] den_w    = {1'b0, cen_den};
    localparam logic [8:0] half_w   = {2'b00, cen_den[7:1]};
    localparam logic [8:0] den_half = den_w + half_w;  // second wrap point for cenb

    logic [8:0] acc;
    logic [8:0] sum;
    logic       wrap;
    logic       busy;
    logic       int_ack;
    logic       as_seen;  // as_n low for a clock, selects settled
    logic       as_cen;   // a cpu_cen has passed inside this cycle

    assign sum  = acc + {2'b00, cen_num};
    assign wrap = sum >= den_w;

    // fractional divider, cen on the wrap and cenb half a period later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc      <= '0;
            cpu_cen  <= 1'b0;
            cpu_cenb <= 1'b0;
        end else begin
            acc      <= wrap ? sum - den_w : sum;
            cpu_cen  <= wrap;
            cpu_cenb <= ((acc < half_w) && (sum >= half_w)) || (sum >= den_half);
        end
    end

    assign busy    = (rom_cs & ~rom_ok) | (ram_cs & ~ram_ok);
    assign int_ack = fc == fc_int_ack;
    assign vpa_n   = ~(~as_n & int_ack);  // autovector
    assign ipl_n   = {irq_n, 2'b11};      // single level interrupt

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            as_seen <= 1'b0;
            as_cen  <= 1'b0;
            dtack_n <= 1'b1;
        end else begin
            as_seen <= ~as_n;
            if (as_n) begin
                as_cen  <= 1'b0;
                dtack_n <= 1'b1;
            end else begin
                if (cpu_cen) as_cen <= 1'b1;
                // writes without strobes wait one extra enable
                if (cpu_cen && as_seen && !int_ack && !busy && (~&cpu_dsn || as_cen))
                    dtack_n <= 1'b0;
            end
        end
    end

    dtack_vpa_excl: assert property (@(posedge clk) disable iff (rst)
        !(!dtack_n && !vpa_n));

endmodule

//--- logic/read_data_path.sv
`timescale 1ns/100ps

module read_data_path
    import sub_bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  rom_cs,
    input  logic  ram_cs,
    input  logic  road_cs,
    input  data_t rom_data,
    input  data_t ram_data,
    input  data_t road_dout,
    input  logic  sub_br,
    output data_t cpu_din,   // to the sub CPU
    output data_t sub_din    // to the main CPU
);

    data_t bus_mux;

    always_comb begin
        if (rom_cs)       bus_mux = rom_data;
        else if (ram_cs)  bus_mux = ram_data;
        else if (road_cs) bus_mux = road_dout;
        else              bus_mux = open_bus;  // sio and unmapped
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= '0;
            sub_din <= '0;
        end else begin
            cpu_din <= bus_mux;
            if (sub_br) sub_din <= bus_mux;  // hold last main read
        end
    end

endmodule

//--- logic/status_regs.sv
`timescale 1ns/100ps

module status_regs
    import sub_bus_pkg::*;
(
    input  logic       clk,
    input  logic [7:0] st_addr,
    input  logic       as_n,
    input  logic       dtack_n,
    input  dsn_t       cpu_dsn,
    input  fc_t        fc,
    input  logic [2:0] ipl_n,
    input  addr_t      cpu_addr,
    input  logic       rom_cs,
    input  logic       ram_cs,
    input  logic       road_cs,
    input  logic       sio_cs,
    input  owner_e     owner,
    output logic [7:0] st_dout
);

    always_ff @(posedge clk) begin
        case (st_addr[3:0])
            4'd4:    st_dout <= {cpu_dsn, dtack_n, as_n, 1'b0, fc};
            4'd5:    st_dout <= {1'b0, ipl_n, 1'b0, fc};
            4'd8:    st_dout <= {cpu_addr[7:1], 1'b0};  // byte address
            4'd9:    st_dout <= cpu_addr[15:8];
            4'd10:   st_dout <= {4'd0, cpu_addr[19:16]};
            4'd11:   st_dout <= {2'd0, owner, sio_cs, road_cs, ram_cs, rom_cs};
            default: st_dout <= 8'd0;
        endcase
    end

endmodule

//--- logic/sub_bus_top.sv
`timescale 1ns/100ps

module sub_bus_top
    import sub_bus_pkg::*;
#(
    parameter logic [6:0] cen_num = 7'd29,
    parameter logic [7:0] cen_den = 8'd146
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        irq_n,       // shared with the main CPU
    // sub CPU pins
    input  addr_t       cpu_addr,
    input  dsn_t        cpu_dsn,
    input  logic        cpu_rnw,
    input  data_t       cpu_wdata,
    input  fc_t         fc,
    input  logic        as_n,
    output data_t       cpu_din,
    output logic        cpu_cen,
    output logic        cpu_cenb,
    output logic        dtack_n,
    output logic        vpa_n,
    output logic [2:0]  ipl_n,
    output logic        bgack_n,
    // main CPU side
    input  addr_t       main_addr,
    input  dsn_t        main_dsn,
    input  logic        main_rnw,
    input  data_t       main_wdata,
    input  logic        sub_br,
    output data_t       sub_din,
    output logic        sub_ok,
    // memories
    output logic [18:1] sub_addr,
    output data_t       cpu_dout,
    output logic        rnw,
    output dsn_t        dsn,
    output logic        rom_cs,
    input  logic        rom_ok,
    input  data_t       rom_data,
    output logic        ram_cs,
    input  logic        ram_ok,
    input  data_t       ram_data,
    output logic        road_cs,
    input  data_t       road_dout,
    output logic        sio_cs,
    // debug readout
    input  logic [7:0]  st_addr,
    output logic [7:0]  st_dout
);

    sub_bus_if bus ();

    owner_e owner;
    logic   bgack_l;  // grant delayed one clock
    logic   busy;

    assign cpu_dout = bus.wdata;
    assign rnw      = bus.rnw;
    assign dsn      = bus.dsn;
    assign busy     = (rom_cs & ~rom_ok) | (ram_cs & ~ram_ok);
    assign sub_ok   = ~bgack_l & ~busy;  // main side may take the data

    always_ff @(posedge clk or posedge rst) begin
        if (rst) bgack_l <= 1'b1;
        else     bgack_l <= bgack_n;
    end

    bus_grant_ctrl bus_grant_ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .sub_br     (sub_br),
        .as_n       (as_n),
        .cpu_cen    (cpu_cen),
        .cpu_addr   (cpu_addr),
        .cpu_dsn    (cpu_dsn),
        .cpu_rnw    (cpu_rnw),
        .cpu_wdata  (cpu_wdata),
        .fc         (fc),
        .main_addr  (main_addr),
        .main_dsn   (main_dsn),
        .main_rnw   (main_rnw),
        .main_wdata (main_wdata),
        .owner      (owner),
        .bgack_n    (bgack_n),
        .bus        (bus.master)
    );

    mem_map_decode mem_map_decode_inst (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus.slave),
        .rom_cs   (rom_cs),
        .ram_cs   (ram_cs),
        .road_cs  (road_cs),
        .sio_cs   (sio_cs),
        .sub_addr (sub_addr)
    );

    cycle_term #(
        .cen_num (cen_num),
        .cen_den (cen_den)
    ) cycle_term_inst (
        .clk      (clk),
        .rst      (rst),
        .as_n     (as_n),
        .fc       (fc),
        .cpu_dsn  (cpu_dsn),
        .rom_cs   (rom_cs),
        .rom_ok   (rom_ok),
        .ram_cs   (ram_cs),
        .ram_ok   (ram_ok),
        .irq_n    (irq_n),
        .cpu_cen  (cpu_cen),
        .cpu_cenb (cpu_cenb),
        .dtack_n  (dtack_n),
        .vpa_n    (vpa_n),
        .ipl_n    (ipl_n)
    );

    read_data_path read_data_path_inst (
        .clk       (clk),
        .rst       (rst),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .road_cs   (road_cs),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .road_dout (road_dout),
        .sub_br    (sub_br),
        .cpu_din   (cpu_din),
        .sub_din   (sub_din)
    );

    status_regs status_regs_inst (
        .clk      (clk),
        .st_addr  (st_addr),
        .as_n     (as_n),
        .dtack_n  (dtack_n),
        .cpu_dsn  (cpu_dsn),
        .fc       (fc),
        .ipl_n    (ipl_n),
        .cpu_addr (cpu_addr),
        .rom_cs   (rom_cs),
        .ram_cs   (ram_cs),
        .road_cs  (road_cs),
        .sio_cs   (sio_cs),
        .owner    (owner),
        .st_dout  (st_dout)
    );

endmodule

//--- testbench/sub_bus_tb_ref.svh
`ifndef SUB_BUS_TB_REF_SVH
`define SUB_BUS_TB_REF_SVH

function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function logic [31:0] rand_next();
    rng = xorshift(rng);
    return rng;
endfunction

function automatic logic [15:0] rom_word(input logic [18:1] a);
    return a[16:1] ^ {a[18:17], 14'h0} ^ 16'ha5c3;
endfunction

function automatic logic [15:0] ram_word(input logic [18:1] a);
    return {a[8:1], a[16:9]} ^ {14'h0, a[18:17]};
endfunction

function automatic logic [15:0] road_word(input logic [18:1] a);
    return a[16:1] + 16'h1111 + {14'h0, a[18:17]};
endfunction

// expected selects as {sio, road, ram, rom}
function automatic logic [3:0] ref_select(input logic [19:1] a, input logic r,
                                          input logic [1:0] ds);
    case (a[19:17])
        3'd0, 3'd1, 3'd2: return 4'b0001;
        3'd3:             return (r || ds != 2'b11) ? 4'b0010 : 4'b0000;
        3'd4:             return a[16] ? 4'b1000 : 4'b0100;
        default:          return 4'b0000;  // unmapped
    endcase
endfunction

function automatic logic [15:0] ref_data(input logic [19:1] a);
    case (a[19:17])
        3'd0, 3'd1, 3'd2: return rom_word(a[18:1]);
        3'd3:             return ram_word(a[18:1]);
        3'd4:             return a[16] ? 16'hffff : road_word(a[18:1]);
        default:          return 16'hffff;
    endcase
endfunction

function automatic logic [7:0] ref_status(input logic [1:0] owner_code, input logic [3:0] sel);
    return {2'b00, owner_code, sel};
endfunction

task automatic check(input string nm, input logic [15:0] e, input logic [15:0] a);
    name_q.push_back(nm);
    exp_q.push_back(e);
    act_q.push_back(a);
    -> chk_ev;
endtask

task automatic report(input string nm, input int err0);
    -> chk_ev;
    #1;
    $display("%s: %0d errors", nm, n_errors - err0);
endtask

// sub CPU starts a cycle and returns at the first sample with dtack_n or vpa_n low
task automatic sub_access(input logic [19:1] a, input logic r, input logic [1:0] ds,
                          input logic [15:0] wd, input logic [2:0] f,
                          output logic [3:0] sel, output logic ram_seen);
    @(posedge clk);
    #2;
    cpu_addr  = a;
    cpu_rnw   = r;
    cpu_dsn   = ds;
    cpu_wdata = wd;
    fc        = f;
    as_n      = 1'b0;
    ram_seen  = 1'b0;
    do begin
        @(negedge clk);
        ram_seen = ram_seen | ram_cs;
    end while (dtack_n && vpa_n);
    sel = {sio_cs, road_cs, ram_cs, rom_cs};
endtask

task automatic end_access();
    @(posedge clk);
    #2;
    as_n    = 1'b1;
    cpu_dsn = 2'b11;
    do @(negedge clk); while (!dtack_n);  // selects are low again here
endtask

task automatic test_memory_map();
    int          err0;
    logic [31:0] r;
    logic [19:1] a;
    logic [3:0]  sel;
    logic        rs;
    err0 = n_errors;
    for (int i = 0; i < 40; i++) begin
        r = rand_next();
        a = r[18:0];
        a[19:17] = i[2:0];  // walk every region code
        sub_access(a, 1'b1, 2'b00, 16'h0, 3'd5, sel, rs);
        check("memory_map", 16'(ref_select(a, 1'b1, 2'b00)), 16'(sel));
        end_access();
    end
    report("memory_map", err0);
endtask

task automatic test_read_data();
    int          err0;
    logic [31:0] r;
    logic [19:1] a;
    logic [3:0]  sel;
    logic        rs;
    err0 = n_errors;
    for (int i = 0; i < 20; i++) begin
        r = rand_next();
        a = r[18:0];
        a[19:17] = 3'(i + 3);
        sub_access(a, 1'b1, 2'b00, 16'h0, 3'd5, sel, rs);
        check("read_dtack", 16'h1, 16'(vpa_n));  // ended by dtack_n, not the autovector
        check("read_data", ref_data(a), cpu_din);
        end_access();
    end
    report("read_data", err0);
endtask

task automatic test_ram_writes();
    int          err0;
    logic [31:0] r;
    logic [19:1] a;
    logic [15:0] wd;
    logic [3:0]  sel;
    logic        rs;
    err0 = n_errors;
    for (int k = 0; k < 4; k++) begin
        r  = rand_next();
        a  = {3'd3, r[15:0]};
        wd = r[31:16];
        sub_access(a, 1'b0, 2'(k), wd, 3'd5, sel, rs);
        if (k == 3) begin
            check("ram_write_nostrobe", 16'h0, 16'(rs));
        end else begin
            check("ram_write_cs", 16'h1, 16'(rs));
            check("ram_write_data", wd, cpu_dout);
            check("ram_write_dsn", 16'(k), 16'(dsn));
            check("ram_write_rnw", 16'h0, 16'(rnw));
        end
        end_access();
    end
    report("ram_writes", err0);
endtask

task automatic test_bus_grant();
    int          err0;
    logic [31:0] r;
    logic [19:1] ma;
    err0 = n_errors;
    @(posedge clk);
    #2;
    main_addr = 19'h01230;
    main_rnw  = 1'b1;
    main_dsn  = 2'b00;
    cpu_addr  = 19'h00400;  // sub CPU cycle in flight when the request arrives
    cpu_rnw   = 1'b1;
    cpu_dsn   = 2'b00;
    fc        = 3'd5;
    as_n      = 1'b0;
    sub_br    = 1'b1;
    do begin
        @(negedge clk);
        check("grant_held", 16'h1, 16'(bgack_n));
    end while (dtack_n);
    @(posedge clk);
    #2;
    check("grant_as_n", 16'h1, 16'(bgack_n));  // last edge with as_n low
    as_n    = 1'b1;
    cpu_dsn = 2'b11;
    while (bgack_n) @(negedge clk);
    for (int j = 0; j < 4; j++) begin
        r  = rand_next();
        ma = {(j % 2 == 0) ? 3'd1 : 3'd3, r[15:0]};
        @(posedge clk);
        #2 main_addr = ma;
        @(posedge clk);
        do @(negedge clk); while (!(sub_ok && (rom_cs || ram_cs)));
        @(negedge clk);
        check("main_read", ref_data(ma), sub_din);
    end
    @(posedge clk);
    #2;
    check("grant_release", 16'h0, 16'(bgack_n));  // grant kept while sub_br high
    sub_br = 1'b0;
    while (!bgack_n) @(negedge clk);
    report("bus_grant", err0);
endtask

task automatic test_int_ack();
    int         err0;
    logic [3:0] sel;
    logic       rs;
    err0 = n_errors;
    @(posedge clk);
    #2 irq_n = 1'b0;
    sub_access(19'h00100, 1'b1, 2'b00, 16'h0, 3'd7, sel, rs);
    repeat (3) begin
        check("int_vpa", 16'h0, 16'(vpa_n));
        check("int_dtack", 16'h1, 16'(dtack_n));
        check("int_select", 16'h0, 16'({sio_cs, road_cs, ram_cs, rom_cs}));
        check("int_ipl", 16'h3, 16'(ipl_n));  // irq_n low on bit 2
        @(negedge clk);
    end
    end_access();
    @(posedge clk);
    #2 irq_n = 1'b1;
    @(negedge clk);
    check("int_ipl_idle", 16'h7, 16'(ipl_n));
    report("int_ack", err0);
endtask

task automatic test_cen_status();
    int         err0;
    int         count;
    int         count_b;
    int         overlap;
    logic [3:0] sel;
    logic       rs;
    err0    = n_errors;
    count   = 0;
    count_b = 0;
    overlap = 0;
    repeat (1460) begin
        @(negedge clk);
        count   += int'(cpu_cen);
        count_b += int'(cpu_cenb);
        overlap += int'(cpu_cen & cpu_cenb);
    end
    check("cen_rate", 16'd290, 16'(count));
    check("cenb_rate", 16'd290, 16'(count_b));
    check("cenb_offset", 16'd0, 16'(overlap));  // half a period away from cen
    @(posedge clk);
    #2 st_addr = 8'd11;
    sub_access(19'h00200, 1'b1, 2'b00, 16'h0, 3'd5, sel, rs);
    check("status_sub", 16'(ref_status(2'd0, ref_select(19'h00200, 1'b1, 2'b00))),
          16'(st_dout));
    end_access();
    @(posedge clk);
    #2;
    main_addr = 19'h00300;
    sub_br    = 1'b1;
    while (bgack_n) @(negedge clk);
    repeat (2) @(negedge clk);
    check("status_main", 16'(ref_status(2'd2, 4'b0001)), 16'(st_dout));
    @(posedge clk);
    #2 sub_br = 1'b0;
    while (!bgack_n) @(negedge clk);
    report("cen_status", err0);
endtask

`endif

//--- testbench/sub_bus_tb.sv
`timescale 1ns/100ps

module sub_bus_tb;

    localparam int accesses = 80;
    localparam longint timeout_ns = longint'(accesses * 200 + 1460 + 200) * 40;

    logic        clk, rst, irq_n, cpu_rnw, as_n, main_rnw, sub_br;
    logic        rom_ok, ram_ok;
    logic [19:1] cpu_addr, main_addr;
    logic [1:0]  cpu_dsn, main_dsn, dsn;
    logic [15:0] cpu_wdata, main_wdata, rom_data, ram_data, road_dout;
    logic [15:0] cpu_din, sub_din, cpu_dout;
    logic [2:0]  fc, ipl_n;
    logic        cpu_cen, cpu_cenb, dtack_n, vpa_n, bgack_n, sub_ok, rnw;
    logic        rom_cs, ram_cs, road_cs, sio_cs;
    logic [18:1] sub_addr;
    logic [7:0]  st_addr, st_dout;

    int          rom_wait, ram_wait;
    int          n_checks, n_errors;
    logic [31:0] rng;
    string       name_q[$];
    logic [15:0] exp_q[$];
    logic [15:0] act_q[$];
    event        chk_ev;

    `include "sub_bus_tb_ref.svh"

    sub_bus_top #(
        .cen_num (7'd29),
        .cen_den (8'd146)
    ) sub_bus_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // memories answer with data from the address at once
    assign rom_data  = rom_word(sub_addr);
    assign ram_data  = ram_word(sub_addr);
    assign road_dout = road_word(sub_addr);

    // ok comes 0 to 5 clocks after a select rises and drops with it
    initial begin
        rom_ok   = 1'b0;
        ram_ok   = 1'b0;
        rom_wait = -1;
        ram_wait = -1;
        forever begin
            @(posedge clk);
            #2;
            if (!rom_cs) begin
                rom_ok   = 1'b0;
                rom_wait = -1;
            end else if (!rom_ok) begin
                if (rom_wait < 0) rom_wait = int'(rand_next() % 6);
                if (rom_wait == 0) rom_ok = 1'b1;
                else rom_wait--;
            end
            if (!ram_cs) begin
                ram_ok   = 1'b0;
                ram_wait = -1;
            end else if (!ram_ok) begin
                if (ram_wait < 0) ram_wait = int'(rand_next() % 6);
                if (ram_wait == 0) ram_ok = 1'b1;
                else ram_wait--;
            end
        end
    end

    // compares what the tests post against the reference values
    initial begin : compare_proc
        string       nm;
        logic [15:0] e;
        logic [15:0] a;
        forever begin
            @(chk_ev);
            while (exp_q.size() > 0) begin
                nm = name_q.pop_front();
                e  = exp_q.pop_front();
                a  = act_q.pop_front();
                n_checks++;
                assert (e === a) else begin
                    n_errors++;
                    $display("error %s expected %h actual %h", nm, e, a);
                end
            end
        end
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired, a bus cycle or grant never completed");
        $display("Test failed");
        $finish;
    end

    initial begin
        rng        = 32'd9;
        n_checks   = 0;
        n_errors   = 0;
        rst        = 1'b1;
        irq_n      = 1'b1;
        cpu_addr   = '0;
        cpu_dsn    = 2'b11;
        cpu_rnw    = 1'b1;
        cpu_wdata  = '0;
        fc         = 3'd0;
        as_n       = 1'b1;
        main_addr  = '0;
        main_dsn   = 2'b11;
        main_rnw   = 1'b1;
        main_wdata = '0;
        sub_br     = 1'b0;
        st_addr    = 8'd0;
        repeat (8) @(posedge clk);
        #2 rst = 1'b0;

        test_memory_map();
        test_read_data();
        test_ram_writes();
        test_bus_grant();
        test_int_ack();
        test_cen_status();

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+testbench
logic/sub_bus_pkg.sv
logic/sub_bus_if.sv
logic/bus_grant_ctrl.sv
logic/mem_map_decode.sv
logic/cycle_term.sv
logic/read_data_path.sv
logic/status_regs.sv
logic/sub_bus_top.sv
testbench/sub_bus_tb.sv

//--- run.sh
#!/bin/sh
# build and run the sub bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module sub_bus_tb -o sub_bus_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sub_bus_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
